//--- stack_pkg.sv
package stack_pkg;

    parameter int data_width  = 32;   // stack and alu word
    parameter int stack_depth = 16;

    // upper nibble of every opcode
    typedef enum logic [3:0] {
        class_nop    = 4'h0,
        class_const  = 4'h1,
        class_binary = 4'h2,
        class_unary  = 4'h3
    } op_class_e;

    // binary selects come first, unary selects after mul
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_shl  = 4'h5,
        alu_shr  = 4'h6,
        alu_mul  = 4'h7,
        alu_neg  = 4'h8,
        alu_not  = 4'h9,
        alu_pass = 4'ha     // unary pass is drop
    } alu_sel_e;

    typedef struct packed {
        op_class_e op_class;
        alu_sel_e  sel;
    } op_alu_t;

    // constant push carries a 4-bit signed immediate
    typedef struct packed {
        op_class_e         op_class;
        logic signed [3:0] imm;
    } op_const_t;

    typedef union packed {
        op_alu_t   alu;
        op_const_t cnst;
    } op_word_t;

endpackage

//--- decoder.sv
`timescale 1ns/10ps

module decoder #(
    parameter int data_width = stack_pkg::data_width
) (
    input  logic [7:0]            op_code,
    output stack_pkg::alu_sel_e   aluop,
    output logic                  isaluop,
    output logic [1:0]            argc,
    output logic [1:0]            stackargs,
    output logic                  stackwb,
    output logic                  constpush,
    output logic [data_width-1:0] constval
);

    stack_pkg::op_word_t word;

    assign word = op_code;

    always_comb begin
        aluop     = stack_pkg::alu_pass;
        isaluop   = 1'b0;
        stackargs = 2'd0;
        stackwb   = 1'b0;
        constpush = 1'b0;

        case (word.alu.op_class)
            stack_pkg::class_const: begin
                constpush = 1'b1;
                stackwb   = 1'b1;
            end
            stack_pkg::class_binary: begin
                // neg, not and pass are not binary, left as nop
                if (word.alu.sel <= stack_pkg::alu_mul) begin
                    aluop     = word.alu.sel;
                    isaluop   = 1'b1;
                    stackargs = 2'd2;
                    stackwb   = 1'b1;
                end
            end
            stack_pkg::class_unary: begin
                case (word.alu.sel)
                    stack_pkg::alu_neg,
                    stack_pkg::alu_not: begin
                        aluop     = word.alu.sel;
                        isaluop   = 1'b1;
                        stackargs = 2'd1;
                        stackwb   = 1'b1;
                    end
                    stack_pkg::alu_pass: begin
                        stackargs = 2'd1;   // drop, pop and discard
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

    assign argc = stackargs;

    // sign-extend the immediate
    assign constval = {{(data_width-4){word.cnst.imm[3]}}, word.cnst.imm};

endmodule

//--- stack32.sv
`timescale 1ns/10ps

module stack32 #(
    parameter int data_width  = stack_pkg::data_width,
    parameter int stack_depth = stack_pkg::stack_depth
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             push,
    input  logic                             trigger,
    input  logic [data_width-1:0]            write_value,
    output logic [data_width-1:0]            read_value,
    output logic                             done_out,
    output logic [data_width-1:0]            top_value,
    output logic [$clog2(stack_depth+1)-1:0] depth,
    output logic                             fault
);

    localparam int addr_w  = (stack_depth > 1) ? $clog2(stack_depth) : 1;
    localparam int count_w = $clog2(stack_depth + 1);

    logic [data_width-1:0] mem [stack_depth];
    logic [count_w-1:0]    count;
    logic                  empty;
    logic                  full;
    logic [addr_w-1:0]     top_idx;     // entry below the pointer
    logic [addr_w-1:0]     free_idx;    // next slot to write

    assign empty    = (count == '0);
    assign full     = (count == count_w'(stack_depth));
    assign top_idx  = addr_w'(count - 1'b1);
    assign free_idx = addr_w'(count);

    assign top_value = empty ? '0 : mem[top_idx];
    assign depth     = count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            done_out <= 1'b0;
            fault    <= 1'b0;
        end else begin
            done_out <= trigger;    // one cycle after the access
            if (trigger) begin
                if (push) begin
                    if (full) begin
                        fault <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end else begin
                    if (empty) begin
                        fault <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trigger) begin
            if (push && !full) begin
                mem[free_idx] <= write_value;
            end
            if (!push) begin
                read_value <= empty ? '0 : mem[top_idx];   // empty pop reads 0
            end
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu #(
    parameter int data_width = stack_pkg::data_width
) (
    input  logic [data_width-1:0] operand_a,
    input  logic [data_width-1:0] operand_b,
    input  stack_pkg::alu_sel_e   op_select,
    output logic [data_width-1:0] result_lo,
    output logic [data_width-1:0] result_hi
);

    localparam int shamt_w = $clog2(data_width);

    logic [shamt_w-1:0]      shamt;
    logic [2*data_width-1:0] product;

    // low bits of b only, 5 for a 32-bit word
    assign shamt   = operand_b[shamt_w-1:0];
    assign product = operand_a * operand_b;

    always_comb begin
        result_hi = '0;
        case (op_select)
            stack_pkg::alu_add: begin
                result_lo = operand_a + operand_b;
            end
            stack_pkg::alu_sub: begin
                result_lo = operand_a - operand_b;
            end
            stack_pkg::alu_and: begin
                result_lo = operand_a & operand_b;
            end
            stack_pkg::alu_or: begin
                result_lo = operand_a | operand_b;
            end
            stack_pkg::alu_xor: begin
                result_lo = operand_a ^ operand_b;
            end
            stack_pkg::alu_shl: begin
                result_lo = operand_a << shamt;
            end
            stack_pkg::alu_shr: begin
                result_lo = operand_a >> shamt;     // logical
            end
            stack_pkg::alu_mul: begin
                result_lo = product[data_width-1:0];
                result_hi = product[2*data_width-1:data_width];
            end
            stack_pkg::alu_neg: begin
                result_lo = '0 - operand_a;
            end
            stack_pkg::alu_not: begin
                result_lo = ~operand_a;
            end
            default: begin
                result_lo = operand_a;  // pass
            end
        endcase
    end

endmodule

//--- control.sv
`timescale 1ns/10ps

module control #(
    parameter int data_width  = stack_pkg::data_width,
    parameter int stack_depth = stack_pkg::stack_depth
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       op_code,
    output logic [1:0]                       argcount,
    output logic                             op_done,
    output logic [data_width-1:0]            top_value,
    output logic [$clog2(stack_depth+1)-1:0] depth,
    output logic                             fault
);

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_fetch = 3'd1;
    localparam logic [2:0] st_load  = 3'd2;
    localparam logic [2:0] st_exec  = 3'd3;
    localparam logic [2:0] st_write = 3'd4;

    stack_pkg::alu_sel_e   aluop;
    logic                  isaluop;
    logic [1:0]            argc;
    logic [1:0]            stackargs;
    logic                  stackwb;
    logic                  constpush;
    logic [data_width-1:0] constval;

    logic                  stack_push;
    logic                  stack_trigger;
    logic [data_width-1:0] stack_write;
    logic [data_width-1:0] stack_read;
    logic                  stack_done;

    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [data_width-1:0] result_lo;

    logic [2:0]            state;
    logic [1:0]            arg_left;    // pops still to issue
    logic                  done;

    decoder #(.data_width(data_width)) i_decoder (
        .op_code   (op_code),
        .aluop     (aluop),
        .isaluop   (isaluop),
        .argc      (argc),
        .stackargs (stackargs),
        .stackwb   (stackwb),
        .constpush (constpush),
        .constval  (constval)
    );

    stack32 #(
        .data_width  (data_width),
        .stack_depth (stack_depth)
    ) i_stack32 (
        .clk         (clk),
        .reset       (reset),
        .push        (stack_push),
        .trigger     (stack_trigger),
        .write_value (stack_write),
        .read_value  (stack_read),
        .done_out    (stack_done),
        .top_value   (top_value),
        .depth       (depth),
        .fault       (fault)
    );

    // high multiply word is not pushed
    alu #(.data_width(data_width)) i_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op_select (aluop),
        .result_lo (result_lo),
        .result_hi ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            arg_left      <= 2'd0;
            done          <= 1'b0;
            stack_trigger <= 1'b0;
            stack_push    <= 1'b0;
        end else begin
            done          <= 1'b0;
            stack_trigger <= 1'b0;
            case (state)
                st_idle: begin
                    // opcode is still held in the cycle done is high
                    if (op_code != 8'h00 && !done) begin
                        arg_left <= stackargs;
                        state    <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (stackargs != 2'd0) begin
                        stack_push    <= 1'b0;
                        stack_trigger <= 1'b1;
                        arg_left      <= arg_left - 1'b1;
                        state         <= st_load;
                    end else begin
                        state <= st_exec;
                    end
                end
                st_load: begin
                    if (stack_done) begin
                        if (arg_left != 2'd0) begin
                            operand_b     <= stack_read;  // top comes off first
                            stack_trigger <= 1'b1;
                            arg_left      <= arg_left - 1'b1;
                        end else begin
                            if (isaluop) begin
                                operand_a <= stack_read;
                            end
                            state <= st_exec;
                        end
                    end
                end
                st_exec: begin
                    if (stackwb) begin
                        if (constpush) begin
                            stack_write <= constval;
                        end else begin
                            stack_write <= result_lo;
                        end
                        stack_push    <= 1'b1;
                        stack_trigger <= 1'b1;
                        state         <= st_write;
                    end else begin
                        done  <= 1'b1;      // drop and nop end here
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (stack_done) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign op_done  = done;
    assign argcount = argc;

endmodule

//--- stack_machine.sv
`timescale 1ns/10ps

module stack_machine #(
    parameter int data_width  = stack_pkg::data_width,
    parameter int stack_depth = stack_pkg::stack_depth
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       op_code,    // held until op_done
    output logic [1:0]                       argcount,
    output logic                             op_done,
    output logic [data_width-1:0]            top_value,
    output logic [$clog2(stack_depth+1)-1:0] depth,
    output logic                             fault
);

    control #(
        .data_width  (data_width),
        .stack_depth (stack_depth)
    ) i_control (
        .clk       (clk),
        .reset     (reset),
        .op_code   (op_code),
        .argcount  (argcount),
        .op_done   (op_done),
        .top_value (top_value),
        .depth     (depth),
        .fault     (fault)
    );

endmodule

//--- tb_stack_machine.sv
`timescale 1ns/10ps

module tb_stack_machine;

    localparam int data_width   = stack_pkg::data_width;
    localparam int stack_depth  = stack_pkg::stack_depth;
    localparam int depth_w      = $clog2(stack_depth + 1);
    localparam int reset_cycles = 4;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [7:0]            op_code;
    logic [1:0]            argcount;
    logic                  op_done;
    logic [data_width-1:0] top_value;
    logic [depth_w-1:0]    depth;
    logic                  fault;

    // one entry per line of stack_cases.txt
    stack_pkg::op_word_t   case_op[$];
    logic [1:0]            case_argc[$];
    logic [data_width-1:0] case_top[$];
    logic [depth_w-1:0]    case_depth[$];
    logic                  case_fault[$];

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    stack_machine #(
        .data_width  (data_width),
        .stack_depth (stack_depth)
    ) i_stack_machine (
        .clk       (clk),
        .reset     (reset),
        .op_code   (op_code),
        .argcount  (argcount),
        .op_done   (op_done),
        .top_value (top_value),
        .depth     (depth),
        .fault     (fault)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout waiting for op_done after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $fatal(1, "run aborted");
        end
    end

    task automatic compare_value(input string name, input logic [data_width-1:0] got,
                                 input logic [data_width-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_argc, f_top, f_depth, f_fault;
        fd = $fopen("stack_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open stack_cases.txt");
            $display("Result: FAILED");
            $fatal(1, "missing case file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h", f_op, f_argc, f_top, f_depth, f_fault);
                    if (n == 5) begin
                        case_op.push_back(f_op[7:0]);
                        case_argc.push_back(f_argc[1:0]);
                        case_top.push_back(f_top[data_width-1:0]);
                        case_depth.push_back(f_depth[depth_w-1:0]);
                        case_fault.push_back(f_fault[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    // hold the opcode until op_done, then release to 00
    task automatic run_opcode(input logic [7:0] code, input logic [1:0] exp_argc);
        op_code <= code;
        @(negedge clk);
        compare_value("argcount", argcount, exp_argc);
        do @(negedge clk); while (!op_done);
        @(posedge clk);
        op_code <= 8'h00;
    endtask

    initial begin
        int unsigned         gap;
        stack_pkg::op_word_t code;
        reset   = 1'b1;
        op_code = 8'h00;
        void'($urandom(32'h8f6b_4ddb));
        read_cases();
        if (case_op.size() == 0) begin
            $display("no cases found in stack_cases.txt");
            $display("Result: FAILED");
            $fatal(1, "empty case file");
        end else begin
            cycle_limit = case_op.size() * 20 + reset_cycles;
            repeat (reset_cycles) @(posedge clk);
            reset <= 1'b0;
            repeat (3) begin   // nothing may start while op_code is 00
                @(negedge clk);
                compare_value("op_done", op_done, 1'b0);
                compare_value("top_value", top_value, '0);
                compare_value("depth", depth, '0);
                compare_value("fault", fault, 1'b0);
            end
            for (int i = 0; i < case_op.size(); i++) begin
                gap = 1 + ($urandom % 3);
                repeat (gap) @(posedge clk);
                code = case_op[i];
                if (code == 8'h00) begin
                    apply_reset();
                end else begin
                    run_opcode(code, case_argc[i]);
                end
                @(negedge clk);
                compare_value("top_value", top_value, case_top[i]);
                compare_value("depth", depth, case_depth[i]);
                compare_value("fault", fault, case_fault[i]);
            end
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- stack_cases.txt
// opcode argcount top_value depth fault, all hex, checked after each op_done
// opcode 00 applies a reset in place of an operation
13 0 00000003 01 0
1f 0 ffffffff 02 0
20 2 00000002 01 0
17 0 00000007 02 0
21 2 fffffffb 01 0   // second minus top
16 0 00000006 02 0
22 2 00000002 01 0
15 0 00000005 02 0
23 2 00000007 01 0
13 0 00000003 02 0
24 2 00000004 01 0
13 0 00000003 02 0
25 2 00000020 01 0
12 0 00000002 02 0
26 2 00000008 01 0
18 0 fffffff8 02 0
27 2 ffffffc0 01 0
11 0 00000001 02 0
26 2 7fffffe0 01 0   // logical shift
38 1 80000020 01 0
39 1 7fffffdf 01 0
1f 0 ffffffff 02 0
3a 1 7fffffdf 01 0
11 0 00000001 02 0
12 0 00000002 03 0
13 0 00000003 04 0
14 0 00000004 05 0
15 0 00000005 06 0
16 0 00000006 07 0
17 0 00000007 08 0
18 0 fffffff8 09 0
19 0 fffffff9 0a 0
1a 0 fffffffa 0b 0
1b 0 fffffffb 0c 0
1c 0 fffffffc 0d 0
1d 0 fffffffd 0e 0
1e 0 fffffffe 0f 0
1f 0 ffffffff 10 0
10 0 ffffffff 10 1   // stack full, push lost
00 0 00000000 00 0
15 0 00000005 01 0
21 2 fffffffb 01 1   // second pop is empty and reads 0
39 1 00000004 01 1

//--- tb.f
stack_pkg.sv
decoder.sv
stack32.sv
alu.sv
control.sv
stack_machine.sv
tb_stack_machine.sv

//--- Bender.yml
package:
  name: stack_machine

sources:
  - stack_pkg.sv
  - decoder.sv
  - stack32.sv
  - alu.sv
  - control.sv
  - stack_machine.sv
  - target: test
    files:
      - tb_stack_machine.sv
